// ==== common/ppu_pkg.sv ====
package ppu_pkg;

  // ============================================================
  // Line and frame timing
  // ============================================================

  // Dots per scanline, every mode included
  localparam int DOTS_PER_LINE = 456;
  // OAM scan length
  localparam int MODE2_LEN = 80;
  // Visible lines plus ten vblank lines
  localparam int LINES_PER_FRAME = 154;
  localparam int SCREEN_HEIGHT = 144;
  localparam int SCREEN_WIDTH = 160;

  // ============================================================
  // CPU address map
  // ============================================================

  // VRAM window
  localparam logic [15:0] VRAM_START = 16'h8000;
  localparam logic [15:0] VRAM_END = 16'h9FFF;
  localparam int VRAM_LEN = 8192;

  // LCD registers, 0xFF46 left unmapped
  localparam logic [15:0] REG_LCDC = 16'hFF40;
  localparam logic [15:0] REG_STAT = 16'hFF41;
  localparam logic [15:0] REG_SCY = 16'hFF42;
  localparam logic [15:0] REG_SCX = 16'hFF43;
  localparam logic [15:0] REG_LY = 16'hFF44;
  localparam logic [15:0] REG_LYC = 16'hFF45;
  localparam logic [15:0] REG_BGP = 16'hFF47;
  localparam logic [15:0] REG_WY = 16'hFF4A;
  localparam logic [15:0] REG_WX = 16'hFF4B;

  // ============================================================
  // Mode codes, as read in STAT[1:0]
  // ============================================================
  localparam logic [1:0] MODE_HBLANK = 2'd0;
  localparam logic [1:0] MODE_VBLANK = 2'd1;
  localparam logic [1:0] MODE_OAM = 2'd2;
  localparam logic [1:0] MODE_XFER = 2'd3;

  // Fetcher steps
  localparam logic [1:0] FETCH_MAP = 2'd0;
  localparam logic [1:0] FETCH_LOW = 2'd1;
  localparam logic [1:0] FETCH_HIGH = 2'd2;
  localparam logic [1:0] FETCH_PUSH = 2'd3;

  // Pixel FIFO, two tiles deep
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

endpackage

// ==== design/ppu_bus_regs.sv ====
`timescale 1ns/1ns

module ppu_bus_regs
  import ppu_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic [15:0] bus_addr,
  input  logic [7:0]  bus_wdata,
  input  logic        bus_write_en,
  input  logic        bus_read_en,
  output logic [7:0]  bus_rdata,
  input  logic [1:0]  mode,
  input  logic [7:0]  ly,
  input  logic        coincidence,
  input  logic        fetch_read,
  input  logic [12:0] fetch_addr,
  output logic [7:0]  fetch_rdata,
  output logic [7:0]  lcdc,
  output logic [7:0]  scx,
  output logic [7:0]  scy,
  output logic [7:0]  lyc,
  output logic [7:0]  bgp,
  output logic [3:0]  stat_en
);

  logic [7:0]  vram [VRAM_LEN];
  logic [7:0]  wy;
  logic [7:0]  wx;
  logic        vram_sel;
  logic        vram_open;
  logic [12:0] vram_idx;

  // ============================================================
  // Decode
  // ============================================================
  assign vram_sel = (bus_addr >= VRAM_START) && (bus_addr <= VRAM_END);
  // CPU locked out of VRAM while the renderer owns it
  assign vram_open = (mode != MODE_XFER);
  assign vram_idx = 13'(bus_addr - VRAM_START);

  // ============================================================
  // VRAM array
  // ============================================================
  always_ff @(posedge clk) begin
    if (bus_write_en && vram_sel && vram_open) begin
      vram[vram_idx] <= bus_wdata;
    end
  end

  // Fetcher port, always served
  assign fetch_rdata = fetch_read ? vram[fetch_addr] : 8'hFF;

  // ============================================================
  // Register file
  // ============================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      // LCD on, BG tile data at 0x8000, BG on
      lcdc    <= 8'h91;
      stat_en <= 4'h0;
      scy     <= 8'h00;
      scx     <= 8'h00;
      lyc     <= 8'h00;
      bgp     <= 8'h00;
      wy      <= 8'h00;
      wx      <= 8'h00;
    end else if (bus_write_en) begin
      case (bus_addr)
        REG_LCDC: lcdc <= bus_wdata;
        // Only the four interrupt enables are writable
        REG_STAT: stat_en <= bus_wdata[6:3];
        REG_SCY:  scy <= bus_wdata;
        REG_SCX:  scx <= bus_wdata;
        REG_LYC:  lyc <= bus_wdata;
        REG_BGP:  bgp <= bus_wdata;
        REG_WY:   wy <= bus_wdata;
        REG_WX:   wx <= bus_wdata;
        // LY is read only
        default:  ;
      endcase
    end
  end

  // ============================================================
  // CPU read mux
  // ============================================================
  always_comb begin
    bus_rdata = 8'hFF;
    if (bus_read_en) begin
      if (vram_sel) begin
        bus_rdata = vram_open ? vram[vram_idx] : 8'hFF;
      end else begin
        case (bus_addr)
          REG_LCDC: bus_rdata = lcdc;
          // Bit 7 always reads back as 1
          REG_STAT: bus_rdata = {1'b1, stat_en, coincidence, mode};
          REG_SCY:  bus_rdata = scy;
          REG_SCX:  bus_rdata = scx;
          REG_LY:   bus_rdata = ly;
          REG_LYC:  bus_rdata = lyc;
          REG_BGP:  bus_rdata = bgp;
          REG_WY:   bus_rdata = wy;
          REG_WX:   bus_rdata = wx;
          // OAM, DMA and anything else float high
          default:  bus_rdata = 8'hFF;
        endcase
      end
    end
  end

endmodule

// ==== design/ppu_timing.sv ====
`timescale 1ns/1ns

module ppu_timing
  import ppu_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       lcdc_on,
  input  logic [7:0] lyc,
  input  logic [3:0] stat_en,
  input  logic       line_done,
  output logic [7:0] ly,
  output logic [1:0] mode,
  output logic       coincidence,
  output logic       flush,
  output logic       vblank_req,
  output logic       stat_req
);

  logic [8:0] dot;
  logic [7:0] ly_next;
  logic       line_end;
  logic [7:0] ly_prev;
  logic [1:0] mode_prev;
  logic       lyc_hit;
  logic       mode_hit;

  assign line_end = (dot == 9'(DOTS_PER_LINE - 1));
  // LY wraps after the last vblank line
  assign ly_next = (ly == 8'(LINES_PER_FRAME - 1)) ? 8'd0 : ly + 8'd1;
  assign coincidence = (ly == lyc);

  // ============================================================
  // Dot and line counters
  // ============================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot        <= 9'd0;
      ly         <= 8'd0;
      vblank_req <= 1'b0;
    end else begin
      vblank_req <= 1'b0;
      if (!lcdc_on) begin
        // LCD off parks the beam at the top left
        dot <= 9'd0;
        ly  <= 8'd0;
      end else if (line_end) begin
        dot <= 9'd0;
        ly  <= ly_next;
        // Entering first vblank line
        if (ly_next == 8'(SCREEN_HEIGHT)) begin
          vblank_req <= 1'b1;
        end
      end else begin
        dot <= dot + 9'd1;
      end
    end
  end

  // ============================================================
  // Mode sequencing
  // ============================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mode  <= MODE_OAM;
      flush <= 1'b0;
    end else begin
      flush <= 1'b0;
      if (!lcdc_on) begin
        mode <= MODE_OAM;
      end else if (line_end) begin
        // Next line decides between scan and vblank
        mode <= (ly_next >= 8'(SCREEN_HEIGHT)) ? MODE_VBLANK : MODE_OAM;
      end else begin
        case (mode)
          MODE_OAM: begin
            if (dot == 9'(MODE2_LEN - 1)) begin
              mode  <= MODE_XFER;
              flush <= 1'b1;
            end
          end
          // Transfer length set by the renderer
          MODE_XFER: begin
            if (line_done) begin
              mode <= MODE_HBLANK;
            end
          end
          // Hblank and vblank only leave at end of line
          default: ;
        endcase
      end
    end
  end

  // ============================================================
  // STAT interrupt
  // ============================================================

  // LY just landed on LYC
  assign lyc_hit = stat_en[3] && (ly != ly_prev) && coincidence;

  // Mode entry, one enable per mode
  always_comb begin
    mode_hit = 1'b0;
    if (mode != mode_prev) begin
      case (mode)
        MODE_OAM:    mode_hit = stat_en[2];
        MODE_VBLANK: mode_hit = stat_en[1];
        MODE_HBLANK: mode_hit = stat_en[0];
        default:     mode_hit = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ly_prev   <= 8'd0;
      mode_prev <= MODE_OAM;
      stat_req  <= 1'b0;
    end else begin
      ly_prev   <= ly;
      mode_prev <= mode;
      stat_req  <= lyc_hit || mode_hit;
    end
  end

endmodule

// ==== renderer/bg_fetcher.sv ====
`timescale 1ns/1ns

module bg_fetcher
  import ppu_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        flush,
  input  logic        xfer,
  input  logic [7:0]  ly,
  input  logic [7:0]  scx,
  input  logic [7:0]  scy,
  input  logic [7:0]  lcdc,
  input  logic [4:0]  count,
  output logic        fetch_read,
  output logic [12:0] fetch_addr,
  input  logic [7:0]  fetch_rdata,
  output logic        push,
  output logic [15:0] push_data
);

  logic [1:0]  state;
  logic [4:0]  tile_x;
  logic [7:0]  tile_num;
  logic [7:0]  data_low;
  logic [7:0]  data_high;
  logic [7:0]  row;
  logic [4:0]  col;
  logic [12:0] map_addr;
  logic [12:0] data_addr;
  logic        active;

  assign active = xfer && !flush;

  // Background coordinates, both wrap naturally
  assign row = ly + scy;
  assign col = scx[7:3] + tile_x;

  // Map at 0x9800 or 0x9C00, 32 tiles per row
  assign map_addr = {2'b11, lcdc[3], row[7:3], col};
  // Unsigned 0x8000 mode, or signed around 0x9000
  // Bit 12 set only for signed indices 0..127
  assign data_addr = {~lcdc[4] & ~tile_num[7], tile_num, row[2:0], state == FETCH_HIGH};

  assign fetch_read = active && (state != FETCH_PUSH);
  assign fetch_addr = (state == FETCH_MAP) ? map_addr : data_addr;

  // Need room for a whole tile
  assign push = active && (state == FETCH_PUSH) && (count <= 5'd8);

  // Leftmost pixel from bit 7, placed in the lowest slot
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      push_data[2*i +: 2] = {data_high[7-i], data_low[7-i]};
    end
  end

  // Step sequencing
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state  <= FETCH_MAP;
      tile_x <= 5'd0;
    end else if (flush) begin
      state  <= FETCH_MAP;
      tile_x <= 5'd0;
    end else if (xfer) begin
      case (state)
        FETCH_MAP:  state <= FETCH_LOW;
        FETCH_LOW:  state <= FETCH_HIGH;
        FETCH_HIGH: state <= FETCH_PUSH;
        default: begin
          if (push) begin
            state  <= FETCH_MAP;
            tile_x <= tile_x + 5'd1;
          end
        end
      endcase
    end
  end

  // Latch each byte as it is read
  always_ff @(posedge clk) begin
    if (fetch_read) begin
      case (state)
        FETCH_MAP: tile_num <= fetch_rdata;
        FETCH_LOW: data_low <= fetch_rdata;
        default:   data_high <= fetch_rdata;
      endcase
    end
  end

endmodule

// ==== renderer/pixel_fifo.sv ====
`timescale 1ns/1ns

module pixel_fifo
  import ppu_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        flush,
  input  logic        push,
  input  logic [15:0] push_data,
  input  logic        pop,
  output logic [1:0]  pop_data,
  output logic        empty,
  output logic [4:0]  count
);

  logic [1:0]            mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;

  // Whole tile lands in one cycle
  always_ff @(posedge clk) begin
    if (push) begin
      for (int i = 0; i < 8; i++) begin
        mem[wr_ptr + FIFO_PTR_W'(i)] <= push_data[2*i +: 2];
      end
    end
  end

  // Pointers wrap on their own width
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= 5'd0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= 5'd0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + FIFO_PTR_W'(8);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + FIFO_PTR_W'(1);
      end
      count <= count + (push ? 5'd8 : 5'd0) - (pop ? 5'd1 : 5'd0);
    end
  end

  assign pop_data = mem[rd_ptr];
  assign empty = (count == 5'd0);

endmodule

// ==== renderer/pixel_output.sv ====
`timescale 1ns/1ns

module pixel_output
  import ppu_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       flush,
  input  logic       xfer,
  input  logic [7:0] scx,
  input  logic [7:0] bgp,
  input  logic       bg_enable,
  input  logic       empty,
  input  logic [1:0] pop_data,
  output logic       pop,
  output logic       pixel_valid,
  output logic [1:0] pixel_shade,
  output logic       line_done
);

  logic [2:0] discard_cnt;
  logic [7:0] x_cnt;
  logic       discard;
  logic [1:0] color;

  // Stop drawing once the line is full
  assign pop = xfer && !flush && !empty && (x_cnt < 8'(SCREEN_WIDTH));
  // Fine scroll eats the first SCX mod 8 pixels
  assign discard = (discard_cnt < scx[2:0]);
  // BG off shows color 0 everywhere
  assign color = bg_enable ? pop_data : 2'b00;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      discard_cnt <= 3'd0;
      x_cnt       <= 8'd0;
      pixel_valid <= 1'b0;
      line_done   <= 1'b0;
    end else begin
      pixel_valid <= 1'b0;
      line_done   <= 1'b0;
      if (flush) begin
        discard_cnt <= 3'd0;
        x_cnt       <= 8'd0;
      end else if (pop) begin
        if (discard) begin
          discard_cnt <= discard_cnt + 3'd1;
        end else begin
          x_cnt       <= x_cnt + 8'd1;
          pixel_valid <= 1'b1;
          // Last pixel of the line
          line_done   <= (x_cnt == 8'(SCREEN_WIDTH - 1));
        end
      end
    end
  end

  // Palette lookup, two BGP bits per color
  always_ff @(posedge clk) begin
    if (pop && !discard) begin
      pixel_shade <= {bgp[{color, 1'b1}], bgp[{color, 1'b0}]};
    end
  end

endmodule

// ==== design/ppu_top.sv ====
`timescale 1ns/1ns

module ppu_top
  import ppu_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic [15:0] bus_addr,
  input  logic [7:0]  bus_wdata,
  input  logic        bus_write_en,
  input  logic        bus_read_en,
  output logic [7:0]  bus_rdata,
  output logic        vblank_req,
  output logic        stat_req,
  output logic        pixel_valid,
  output logic [1:0]  pixel_shade
);

  // Register outputs
  logic [7:0]  lcdc;
  logic [7:0]  scx;
  logic [7:0]  scy;
  logic [7:0]  lyc;
  logic [7:0]  bgp;
  logic [3:0]  stat_en;

  // Timing outputs
  logic [7:0]  ly;
  logic [1:0]  mode;
  logic        coincidence;
  logic        flush;
  logic        xfer;
  logic        line_done;

  // Renderer links
  logic        fetch_read;
  logic [12:0] fetch_addr;
  logic [7:0]  fetch_rdata;
  logic        push;
  logic [15:0] push_data;
  logic [4:0]  count;
  logic        pop;
  logic [1:0]  pop_data;
  logic        empty;

  assign xfer = (mode == MODE_XFER);

  // ============================================================
  // Bus side
  // ============================================================
  ppu_bus_regs u_bus_regs (
    .clk         (clk),
    .reset       (reset),
    .bus_addr    (bus_addr),
    .bus_wdata   (bus_wdata),
    .bus_write_en(bus_write_en),
    .bus_read_en (bus_read_en),
    .bus_rdata   (bus_rdata),
    .mode        (mode),
    .ly          (ly),
    .coincidence (coincidence),
    .fetch_read  (fetch_read),
    .fetch_addr  (fetch_addr),
    .fetch_rdata (fetch_rdata),
    .lcdc        (lcdc),
    .scx         (scx),
    .scy         (scy),
    .lyc         (lyc),
    .bgp         (bgp),
    .stat_en     (stat_en)
  );

  ppu_timing u_timing (
    .clk        (clk),
    .reset      (reset),
    .lcdc_on    (lcdc[7]),
    .lyc        (lyc),
    .stat_en    (stat_en),
    .line_done  (line_done),
    .ly         (ly),
    .mode       (mode),
    .coincidence(coincidence),
    .flush      (flush),
    .vblank_req (vblank_req),
    .stat_req   (stat_req)
  );

  // ============================================================
  // Background renderer
  // ============================================================
  bg_fetcher u_fetcher (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .xfer       (xfer),
    .ly         (ly),
    .scx        (scx),
    .scy        (scy),
    .lcdc       (lcdc),
    .count      (count),
    .fetch_read (fetch_read),
    .fetch_addr (fetch_addr),
    .fetch_rdata(fetch_rdata),
    .push       (push),
    .push_data  (push_data)
  );

  pixel_fifo u_fifo (
    .clk      (clk),
    .reset    (reset),
    .flush    (flush),
    .push     (push),
    .push_data(push_data),
    .pop      (pop),
    .pop_data (pop_data),
    .empty    (empty),
    .count    (count)
  );

  pixel_output u_output (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .xfer       (xfer),
    .scx        (scx),
    .bgp        (bgp),
    .bg_enable  (lcdc[0]),
    .empty      (empty),
    .pop_data   (pop_data),
    .pop        (pop),
    .pixel_valid(pixel_valid),
    .pixel_shade(pixel_shade),
    .line_done  (line_done)
  );

endmodule

// ==== sim/ppu_tb.sv ====
`timescale 1ns/1ns

module ppu_tb
  import ppu_pkg::*;
;

  // Pulse selectors for wait_pulse
  localparam int SIG_VBLANK = 0;
  localparam int SIG_STAT = 1;
  localparam int FRAME_CYCLES = 70224;
  localparam int LONG_WAIT = 80000;

  // Plain read/write registers
  localparam logic [15:0] RW_REGS [7] = '{REG_LCDC, REG_SCY, REG_SCX, REG_LYC,
                                          REG_BGP, REG_WY, REG_WX};

  logic        clk;
  logic        reset;
  logic [15:0] bus_addr;
  logic [7:0]  bus_wdata;
  logic        bus_write_en;
  logic        bus_read_en;
  logic [7:0]  bus_rdata;
  logic        vblank_req;
  logic        stat_req;
  logic        pixel_valid;
  logic [1:0]  pixel_shade;

  // Shadow copy of VRAM for expected pixels
  logic [7:0]  vram_model [VRAM_LEN];
  string       cur_test;
  int          tests;
  int          checks;
  int          errors;
  int          test_errors;
  int          rnd;

  ppu_top DUT (
    .clk         (clk),
    .reset       (reset),
    .bus_addr    (bus_addr),
    .bus_wdata   (bus_wdata),
    .bus_write_en(bus_write_en),
    .bus_read_en (bus_read_en),
    .bus_rdata   (bus_rdata),
    .vblank_req  (vblank_req),
    .stat_req    (stat_req),
    .pixel_valid (pixel_valid),
    .pixel_shade (pixel_shade)
  );

  always #2 clk = ~clk;

  // ============================================================
  // Bookkeeping
  // ============================================================
  task automatic begin_test(input string name);
    cur_test = name;
    test_errors = 0;
    tests++;
  endtask

  task automatic end_test();
    if (test_errors == 0) begin
      $display("%s: ok", cur_test);
    end else begin
      $display("%s: %0d errors", cur_test, test_errors);
    end
  endtask

  task automatic check_val(input string name, input int expected, input int actual);
    checks++;
    if (expected != actual) begin
      errors++;
      test_errors++;
      $display("ERR %s %s: expected 0x%0h actual 0x%0h", cur_test, name, expected, actual);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    test_errors++;
    $display("timeout waiting for %s in %s", what, cur_test);
  endtask

  // ============================================================
  // Bus access
  // ============================================================

  // Write lands on the edge after the drive point
  task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
    @(posedge clk);
    #1;
    bus_addr = addr;
    bus_wdata = data;
    bus_read_en = 1'b0;
    bus_write_en = 1'b1;
    @(posedge clk);
    #1;
    bus_write_en = 1'b0;
  endtask

  // rdata is combinational, sampled mid cycle
  task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
    @(posedge clk);
    #1;
    bus_addr = addr;
    bus_read_en = 1'b1;
    #1;
    data = bus_rdata;
  endtask

  function automatic bit pulse_seen(input int which);
    if (which == SIG_VBLANK) begin
      return vblank_req;
    end
    return stat_req;
  endfunction

  // Cycles counted from the call to the pulse
  task automatic wait_pulse(input string what, input int which, input int limit,
                            output int cycles);
    int n;
    bit seen;
    n = 0;
    seen = 1'b0;
    while (!seen && n < limit) begin
      @(posedge clk);
      #1;
      n++;
      seen = pulse_seen(which);
    end
    if (!seen) begin
      report_timeout(what);
    end
    cycles = n;
  endtask

  // Poll STAT until the mode matches, or stops matching
  task automatic wait_mode(input logic [1:0] m, input bit match, input int limit);
    logic [7:0] d;
    int n;
    bit hit;
    n = 0;
    hit = 1'b0;
    while (!hit && n < limit) begin
      bus_read(REG_STAT, d);
      n++;
      hit = ((d[1:0] == m) == match);
    end
    if (!hit) begin
      report_timeout($sformatf("mode %0d (match %0d)", m, match));
    end
  endtask

  // Random bytes over the whole VRAM, LCD must be off
  task automatic fill_vram();
    logic [7:0] d;
    for (int a = 0; a < VRAM_LEN; a++) begin
      d = 8'($urandom());
      vram_model[13'(a)] = d;
      bus_write(VRAM_START + 16'(a), d);
    end
  endtask

  function automatic int model_at(input int a);
    return int'(vram_model[13'(a)]);
  endfunction

  // ============================================================
  // Reference model for line 0
  // ============================================================
  function automatic int expected_shade(input int i, input logic [7:0] lcdc,
                                        input logic [7:0] scx, input logic [7:0] scy,
                                        input logic [7:0] bgp);
    int px;
    int row;
    int map_a;
    int tile;
    int data_a;
    int b;
    int lo;
    int hi;
    int ci;
    // Screen x plus scroll, wrapped to the 256 wide map
    px = (int'(scx) + i) % 256;
    row = int'(scy) % 256;
    map_a = (lcdc[3] ? 32'h1C00 : 32'h1800) + (row / 8) * 32 + (px / 8) % 32;
    tile = model_at(map_a);
    if (lcdc[4]) begin
      data_a = tile * 16;
    end else begin
      // Signed index based at 0x9000
      data_a = 32'h1000 + ((tile < 128) ? tile : tile - 256) * 16;
    end
    data_a = data_a + (row % 8) * 2;
    lo = model_at(data_a);
    hi = model_at(data_a + 1);
    b = 7 - (px % 8);
    ci = 2 * ((hi >> b) & 1) + ((lo >> b) & 1);
    if (!lcdc[0]) begin
      ci = 0;
    end
    return (int'(bgp) >> (2 * ci)) & 3;
  endfunction

  // ============================================================
  // Directed tests
  // ============================================================
  task automatic registers_rw();
    logic [7:0] w;
    logic [7:0] d;
    begin_test("registers");
    for (int i = 0; i < 7; i++) begin
      w = 8'($urandom());
      bus_write(RW_REGS[i], w);
      bus_read(RW_REGS[i], d);
      check_val($sformatf("reg 0x%04h", RW_REGS[i]), int'(w), int'(d));
    end
    // Only enables stick, bit 7 fixed high
    w = 8'($urandom());
    bus_write(REG_STAT, w);
    bus_read(REG_STAT, d);
    check_val("STAT upper bits", int'({1'b1, w[6:3], 3'b000}), int'(d & 8'hF8));
    bus_write(REG_STAT, 8'h00);
    // Restart the frame so LY sits at 0 for a whole line
    bus_write(REG_LCDC, 8'h11);
    bus_write(REG_LCDC, 8'h91);
    bus_write(REG_LY, 8'h5A);
    bus_read(REG_LY, d);
    check_val("LY write", 0, int'(d));
    bus_write(REG_LCDC, 8'h11);
    bus_read(16'hFF46, d);
    check_val("DMA reg", 8'hFF, int'(d));
    bus_read(16'hFE00, d);
    check_val("OAM", 8'hFF, int'(d));
    // Read strobe low on a live register
    @(posedge clk);
    #1;
    bus_addr = REG_LCDC;
    bus_read_en = 1'b0;
    #1;
    check_val("read_en low", 8'hFF, int'(bus_rdata));
    end_test();
  endtask

  task automatic lcd_off_hold();
    logic [7:0] d;
    begin_test("lcd off");
    for (int k = 0; k < 4; k++) begin
      repeat (1 + ($urandom() % 2000)) @(posedge clk);
      bus_read(REG_LY, d);
      check_val("LY", 0, int'(d));
      bus_read(REG_STAT, d);
      check_val("mode", 2, int'(d[1:0]));
    end
    fill_vram();
    for (int a = 0; a < VRAM_LEN; a++) begin
      bus_read(VRAM_START + 16'(a), d);
      check_val($sformatf("vram 0x%04h", a), model_at(a), int'(d));
    end
    end_test();
  endtask

  task automatic frame_timing();
    logic [7:0] d;
    int n;
    begin_test("frame timing");
    bus_write(REG_LCDC, 8'h91);
    wait_pulse("vblank_req", SIG_VBLANK, LONG_WAIT, n);
    wait_pulse("vblank_req", SIG_VBLANK, LONG_WAIT, n);
    check_val("frame cycles", FRAME_CYCLES, n);
    bus_read(REG_LY, d);
    check_val("LY at vblank", 144, int'(d));
    end_test();
  endtask

  task automatic vram_lockout();
    logic [15:0] a;
    logic [7:0]  k;
    logic [7:0]  d;
    begin_test("vram lockout");
    a = VRAM_START + 16'(13'($urandom()));
    k = vram_model[13'(a - VRAM_START)];
    // A byte of 0xFF would hide the read block
    while (k == 8'hFF) begin
      a = VRAM_START + 16'(13'($urandom()));
      k = vram_model[13'(a - VRAM_START)];
    end
    // Catch the start of a transfer, not its tail
    wait_mode(MODE_XFER, 1'b0, LONG_WAIT);
    wait_mode(MODE_XFER, 1'b1, LONG_WAIT);
    bus_read(a, d);
    check_val("read in mode 3", 8'hFF, int'(d));
    bus_write(a, ~k);
    wait_mode(MODE_HBLANK, 1'b1, LONG_WAIT);
    bus_read(a, d);
    check_val("write in mode 3", int'(k), int'(d));
    end_test();
  endtask

  task automatic stat_interrupts();
    logic [7:0] d;
    int n;
    begin_test("stat irq");
    bus_write(REG_LYC, 8'd5);
    bus_write(REG_STAT, 8'h40);
    wait_pulse("LYC stat_req", SIG_STAT, LONG_WAIT, n);
    wait_pulse("LYC stat_req", SIG_STAT, LONG_WAIT, n);
    check_val("LYC period", FRAME_CYCLES, n);
    bus_read(REG_LY, d);
    check_val("LY at LYC", 5, int'(d));
    // Hblank entries, starting from line 0
    bus_write(REG_STAT, 8'h08);
    wait_pulse("vblank_req", SIG_VBLANK, LONG_WAIT, n);
    wait_pulse("hblank stat_req", SIG_STAT, LONG_WAIT, n);
    for (int i = 0; i < 5; i++) begin
      wait_pulse("hblank stat_req", SIG_STAT, 1000, n);
      check_val($sformatf("hblank gap %0d", i), DOTS_PER_LINE, n);
    end
    bus_write(REG_STAT, 8'h00);
    end_test();
  endtask

  task automatic capture_line(input bit tile_sel);
    logic [7:0] scy_v;
    logic [7:0] scx_v;
    logic [7:0] bgp_v;
    logic [7:0] lcdc_v;
    logic [1:0] got [$];
    int n;
    bit done;
    scy_v = 8'($urandom());
    scx_v = 8'($urandom());
    bgp_v = 8'($urandom());
    lcdc_v = 8'h81 | {3'b000, tile_sel, 4'b0000} | (8'($urandom()) & 8'h08);
    bus_write(REG_LCDC, lcdc_v & 8'h7F);
    bus_write(REG_SCY, scy_v);
    bus_write(REG_SCX, scx_v);
    bus_write(REG_BGP, bgp_v);
    // LCD on restarts at line 0, dot 0
    bus_write(REG_LCDC, lcdc_v);
    @(posedge clk);
    #1;
    bus_addr = REG_STAT;
    bus_read_en = 1'b1;
    n = 0;
    done = 1'b0;
    while (!done && n < 1000) begin
      @(posedge clk);
      #1;
      n++;
      if (pixel_valid) begin
        got.push_back(pixel_shade);
      end
      done = (bus_rdata[1:0] == MODE_HBLANK);
    end
    if (!done) begin
      report_timeout("mode 0 on line 0");
    end
    check_val($sformatf("pixel count, tile_sel %0d", tile_sel), SCREEN_WIDTH, got.size());
    for (int i = 0; i < got.size() && i < SCREEN_WIDTH; i++) begin
      check_val($sformatf("pixel %0d, tile_sel %0d", i, tile_sel),
                expected_shade(i, lcdc_v, scx_v, scy_v, bgp_v), int'(got[i]));
    end
  endtask

  task automatic pixel_stream();
    begin_test("pixel stream");
    bus_write(REG_LCDC, 8'h11);
    fill_vram();
    capture_line(1'b1);
    capture_line(1'b0);
    end_test();
  endtask

  // ============================================================
  // Main sequence
  // ============================================================
  initial begin
    clk = 1'b0;
    reset = 1'b1;
    bus_addr = 16'h0000;
    bus_wdata = 8'h00;
    bus_write_en = 1'b0;
    bus_read_en = 1'b0;
    tests = 0;
    checks = 0;
    errors = 0;
    test_errors = 0;
    cur_test = "reset";
    rnd = $urandom(30063);
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    registers_rw();
    lcd_off_hold();
    frame_timing();
    vram_lockout();
    stat_interrupts();
    pixel_stream();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
common/ppu_pkg.sv
design/ppu_bus_regs.sv
design/ppu_timing.sv
renderer/bg_fetcher.sv
renderer/pixel_fifo.sv
renderer/pixel_output.sv
design/ppu_top.sv
sim/ppu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0
TOP       := ppu_tb
FILELIST  := build.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
